/* verilog/vlsu_frag_pkg.sv */
// --------------------------------------------------------------------------
// Shared definitions for the vector load/store request fragmenter.
// Every block refers to these by scoped name.
// --------------------------------------------------------------------------
package vlsu_frag_pkg;

  // Request mode, unit-stride or one element per segment
  typedef enum logic [1:0] {
    MODE_INCR = 2'd0,
    MODE_STRD = 2'd1
  } frag_mode_e;

  // Transactions never cross a page of 2**PageBits bytes
  localparam int unsigned PageBits = 12;
  localparam int unsigned PageSize = 1 << PageBits;

  // Element width code, element size is 1 << sew bytes
  localparam int unsigned SewWidth = 2;

  // Length and start index, up to 256 elements
  localparam int unsigned LenWidth = 9;

  // Widest segment in bytes is the longest vector at the widest element
  localparam int unsigned SegBytesWidth = LenWidth + (1 << SewWidth) - 1;

  // Transaction index, count and total
  localparam int unsigned TxnCntWidth = 10;

endpackage

/* verilog/seg_txn_plan.sv */
// --------------------------------------------------------------------------
// Segment planner. Splits one segment at page boundaries and reports the
// index of its last transaction and where that transaction ends in its page.
// Purely combinational, shared by request accept, segment init and advance.
// --------------------------------------------------------------------------
module seg_txn_plan #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic [AddrWidth-1:0]                   seg_addr_i,
  input  logic [vlsu_frag_pkg::SegBytesWidth-1:0] seg_bytes_i,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0]   txn_num_o,
  output logic [vlsu_frag_pkg::PageBits:0]        last_bytes_o
);

  // Room for a full page offset plus the longest segment
  localparam int unsigned SpanWidth = vlsu_frag_pkg::PageBits + 2;

  logic [SpanWidth-1:0] span;
  logic [SpanWidth-1:0] span_m1;
  logic [vlsu_frag_pkg::PageBits-1:0] end_off;

  // Bytes from the page start of the first piece to the segment end
  assign span = SpanWidth'(seg_addr_i[vlsu_frag_pkg::PageBits-1:0])
              + SpanWidth'(seg_bytes_i);

  // Last byte position, its page number is the number of crossings
  assign span_m1   = span - SpanWidth'(1);
  assign txn_num_o = vlsu_frag_pkg::TxnCntWidth'(span_m1 >> vlsu_frag_pkg::PageBits);

  // End offset of the final piece, zero means it fills its page
  assign end_off = span[vlsu_frag_pkg::PageBits-1:0];

  always_comb begin
    if (end_off == '0) begin
      last_bytes_o = (vlsu_frag_pkg::PageBits + 1)'(vlsu_frag_pkg::PageSize);
    end else begin
      last_bytes_o = {1'b0, end_off};
    end
  end

endmodule

/* verilog/vreq_fragmenter.sv */
// --------------------------------------------------------------------------
// Request fragmenter FSM. Latches one vector request, walks its segments
// and page pieces, and hands segment metadata to the issue stage. Pulses
// one commit record into the metadata queue when fragmenting begins.
// --------------------------------------------------------------------------
module vreq_fragmenter #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned IdWidth   = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  logic [AddrWidth-1:0]                  req_base_addr_i,
  input  logic [vlsu_frag_pkg::SewWidth-1:0]    req_sew_i,
  input  logic [vlsu_frag_pkg::LenWidth-1:0]    req_len_i,
  input  logic [vlsu_frag_pkg::LenWidth-1:0]    req_vstart_i,
  input  logic [AddrWidth-1:0]                  req_stride_i,
  input  vlsu_frag_pkg::frag_mode_e             req_mode_i,
  input  logic [IdWidth-1:0]                    req_id_i,
  input  logic                                  req_is_load_i,
  input  logic                                  req_vm_i,
  input  logic                                  core_st_pending_i,
  input  logic                                  meta_full_i,
  input  logic                                  meta_ready_i,
  output logic                                  meta_valid_o,
  output logic [AddrWidth-1:0]                  seg_addr_o,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_idx_o,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_num_o,
  output logic [vlsu_frag_pkg::PageBits:0]      last_bytes_o,
  output logic                                  vm_o,
  output logic                                  enq_o,
  output logic [IdWidth-1:0]                    enq_id_o,
  output logic                                  enq_is_load_o,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0] enq_txn_total_o
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StSegInit = 2'd1;
  localparam logic [1:0] StFrag    = 2'd2;
  localparam logic [1:0] StStall   = 2'd3;

  logic [1:0] state_q, state_d;
  logic       enq_q, enq_d;
  logic       stall, last_txn, last_seg, step_seg;

  // Control counters
  logic [vlsu_frag_pkg::LenWidth-1:0]    rmn_seg_q;
  logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_idx_q, txn_num_q;

  // Latched request and current segment
  vlsu_frag_pkg::frag_mode_e             mode_q;
  logic [vlsu_frag_pkg::SewWidth-1:0]    sew_q;
  logic [vlsu_frag_pkg::LenWidth-1:0]    eff_q;
  logic [AddrWidth-1:0]                  stride_q, base_q, seg_addr_q;
  logic [IdWidth-1:0]                    id_q;
  logic                                  is_load_q, vm_q;
  logic [vlsu_frag_pkg::TxnCntWidth-1:0] total_q;
  logic [vlsu_frag_pkg::PageBits:0]      last_bytes_q;

  // Planner operands and results
  logic [vlsu_frag_pkg::LenWidth-1:0]      eff_elems;
  logic [AddrWidth-1:0]                    start_addr, plan_addr;
  logic [vlsu_frag_pkg::SegBytesWidth-1:0] seg_bytes, plan_bytes;
  logic [vlsu_frag_pkg::TxnCntWidth-1:0]   plan_txn_num;
  logic [vlsu_frag_pkg::PageBits:0]        plan_last;

  assign stall    = core_st_pending_i || meta_full_i;
  assign last_txn = (txn_idx_q == txn_num_q);
  assign last_seg = (rmn_seg_q == '0);
  assign step_seg = (state_q == StFrag) && meta_ready_i && last_txn && !last_seg;

  // First element address of the incoming request
  assign eff_elems  = req_len_i - req_vstart_i;
  assign start_addr = (req_mode_i == vlsu_frag_pkg::MODE_INCR)
                    ? req_base_addr_i + (AddrWidth'(req_vstart_i) << req_sew_i)
                    : req_base_addr_i + AddrWidth'(req_vstart_i) * req_stride_i;

  // Whole active span for unit-stride, a single element otherwise
  assign seg_bytes = (mode_q == vlsu_frag_pkg::MODE_INCR)
                   ? vlsu_frag_pkg::SegBytesWidth'(eff_q) << sew_q
                   : vlsu_frag_pkg::SegBytesWidth'(1) << sew_q;

  // One planner serves accept (total), init and strided advance
  always_comb begin
    case (state_q)
      StIdle: begin
        plan_addr  = start_addr;
        plan_bytes = vlsu_frag_pkg::SegBytesWidth'(eff_elems) << req_sew_i;
      end
      StSegInit: begin
        plan_addr  = base_q;
        plan_bytes = seg_bytes;
      end
      default: begin
        plan_addr  = seg_addr_q + stride_q;
        plan_bytes = seg_bytes;
      end
    endcase
  end

  seg_txn_plan #(
    .AddrWidth    (AddrWidth)
  ) u_plan (
    .seg_addr_i   (plan_addr),
    .seg_bytes_i  (plan_bytes),
    .txn_num_o    (plan_txn_num),
    .last_bytes_o (plan_last)
  );

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:    if (req_valid_i) state_d = StSegInit;
      StSegInit,
      StStall:   state_d = stall ? StStall : StFrag;
      default:   if (meta_ready_i && last_txn && last_seg) state_d = StIdle;
    endcase
  end

  // Enqueue pulse marks the first fragmenting cycle
  assign enq_d = ((state_q == StSegInit) || (state_q == StStall)) && !stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      enq_q     <= 1'b0;
      rmn_seg_q <= '0;
      txn_idx_q <= '0;
      txn_num_q <= '0;
    end else begin
      state_q <= state_d;
      enq_q   <= enq_d;
      if ((state_q == StIdle) && req_valid_i) begin
        // Strided requests have one segment per active element
        rmn_seg_q <= (req_mode_i == vlsu_frag_pkg::MODE_INCR) ? '0 : eff_elems - 1'b1;
      end
      if ((state_q == StSegInit) || step_seg) begin
        txn_idx_q <= '0;
        txn_num_q <= plan_txn_num;
      end else if ((state_q == StFrag) && meta_ready_i && !last_txn) begin
        txn_idx_q <= txn_idx_q + 1'b1;
      end
      if (step_seg) rmn_seg_q <= rmn_seg_q - 1'b1;
    end
  end

  // Request and segment payload
  always_ff @(posedge clk_i) begin
    if ((state_q == StIdle) && req_valid_i) begin
      mode_q    <= req_mode_i;
      sew_q     <= req_sew_i;
      eff_q     <= eff_elems;
      stride_q  <= req_stride_i;
      base_q    <= start_addr;
      id_q      <= req_id_i;
      is_load_q <= req_is_load_i;
      vm_q      <= req_vm_i;
      // Record total, exact for unit-stride, one per element for strided
      total_q   <= (req_mode_i == vlsu_frag_pkg::MODE_INCR)
                 ? plan_txn_num + 1'b1
                 : vlsu_frag_pkg::TxnCntWidth'(eff_elems);
    end
    if ((state_q == StSegInit) || step_seg) begin
      seg_addr_q   <= plan_addr;
      last_bytes_q <= plan_last;
    end
  end

  assign req_ready_o     = (state_q == StIdle);
  assign meta_valid_o    = (state_q == StFrag);
  assign seg_addr_o      = seg_addr_q;
  assign txn_idx_o       = txn_idx_q;
  assign txn_num_o       = txn_num_q;
  assign last_bytes_o    = last_bytes_q;
  assign vm_o            = vm_q;
  assign enq_o           = enq_q;
  assign enq_id_o        = id_q;
  assign enq_is_load_o   = is_load_q;
  assign enq_txn_total_o = total_q;

  // Queue space was checked the cycle before the pulse
  a_enq_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    enq_o |-> !meta_full_i);

  // No record pending and no segment left once back in idle
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == StIdle) |-> !enq_o && last_seg);

endmodule

/* verilog/txn_issue_reg.sv */
// --------------------------------------------------------------------------
// Transaction issue stage. Turns segment metadata into one page-bounded
// transaction and holds it in a register slice until the memory side takes it.
// --------------------------------------------------------------------------
module txn_issue_reg #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  meta_valid_i,
  output logic                                  meta_ready_o,
  input  logic [AddrWidth-1:0]                  seg_addr_i,
  input  logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_idx_i,
  input  logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_num_i,
  input  logic [vlsu_frag_pkg::PageBits:0]      last_bytes_i,
  input  logic                                  vm_i,
  output logic                                  txn_valid_o,
  input  logic                                  txn_ready_i,
  output logic [AddrWidth-1:0]                  txn_addr_o,
  output logic [vlsu_frag_pkg::PageBits:0]      txn_bytes_o,
  output logic                                  txn_vm_o
);

  localparam int unsigned PB = vlsu_frag_pkg::PageBits;

  logic [AddrWidth-1:0] page_base, addr_d;
  logic [PB:0]          page_off, end_bytes, bytes_d;
  logic                 valid_q;

  assign page_base = {seg_addr_i[AddrWidth-1:PB], {PB{1'b0}}};
  assign page_off  = {1'b0, seg_addr_i[PB-1:0]};

  // First piece starts at the segment base, later ones on page starts
  assign addr_d = (txn_idx_i == '0)
                ? seg_addr_i
                : page_base + (AddrWidth'(txn_idx_i) << PB);

  // Final piece ends where the plan says, the others at the page end
  assign end_bytes = (txn_idx_i == txn_num_i) ? last_bytes_i : (PB + 1)'(vlsu_frag_pkg::PageSize);
  assign bytes_d   = end_bytes - ((txn_idx_i == '0) ? page_off : '0);

  // Slot frees up when empty or drained this cycle
  assign meta_ready_o = !valid_q || txn_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (meta_ready_o) begin
      valid_q <= meta_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_ready_o && meta_valid_i) begin
      txn_addr_o  <= addr_d;
      txn_bytes_o <= bytes_d;
      txn_vm_o    <= vm_i;
    end
  end

  assign txn_valid_o = valid_q;

  // Offered transaction holds until accepted
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_valid_o && !txn_ready_i |=> txn_valid_o && $stable(txn_addr_o)
      && $stable(txn_bytes_o) && $stable(txn_vm_o));

endmodule

/* verilog/cmt_meta_fifo.sv */
// --------------------------------------------------------------------------
// Commit metadata queue, one record per request. Circular buffer with
// a count; full is combinational, a written record is readable next cycle.
// --------------------------------------------------------------------------
module cmt_meta_fifo #(
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned MetaDepth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  enq_i,
  input  logic [IdWidth-1:0]                    id_i,
  input  logic                                  is_load_i,
  input  logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_total_i,
  input  logic                                  deq_i,
  output logic                                  full_o,
  output logic                                  cmt_valid_o,
  output logic [IdWidth-1:0]                    cmt_id_o,
  output logic                                  cmt_is_load_o,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0] cmt_txn_total_o
);

  localparam int unsigned PtrWidth = (MetaDepth > 1) ? $clog2(MetaDepth) : 1;
  localparam int unsigned CntWidth = $clog2(MetaDepth + 1);

  logic [IdWidth-1:0]                    id_mem    [MetaDepth];
  logic                                  load_mem  [MetaDepth];
  logic [vlsu_frag_pkg::TxnCntWidth-1:0] total_mem [MetaDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                do_deq;

  assign full_o      = (cnt_q == CntWidth'(MetaDepth));
  assign cmt_valid_o = (cnt_q != '0);
  assign do_deq      = cmt_valid_o && deq_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at the depth, not at a power of two
      if (enq_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MetaDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_deq) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MetaDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntWidth'(enq_i) - CntWidth'(do_deq);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq_i) begin
      id_mem[wr_ptr_q]    <= id_i;
      load_mem[wr_ptr_q]  <= is_load_i;
      total_mem[wr_ptr_q] <= txn_total_i;
    end
  end

  assign cmt_id_o        = id_mem[rd_ptr_q];
  assign cmt_is_load_o   = load_mem[rd_ptr_q];
  assign cmt_txn_total_o = total_mem[rd_ptr_q];

  // Writer must wait for space, a record is never dropped
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    enq_i |-> !full_o);

endmodule

/* verilog/vlsu_frag_top.sv */
// --------------------------------------------------------------------------
// Vector load/store request splitter top. Takes one request at a time,
// emits page-bounded transactions and one commit record per request.
// --------------------------------------------------------------------------
module vlsu_frag_top #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned MetaDepth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Request input
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  logic [AddrWidth-1:0]                  req_base_addr_i,
  input  logic [vlsu_frag_pkg::SewWidth-1:0]    req_sew_i,
  input  logic [vlsu_frag_pkg::LenWidth-1:0]    req_len_i,
  input  logic [vlsu_frag_pkg::LenWidth-1:0]    req_vstart_i,
  input  logic [AddrWidth-1:0]                  req_stride_i,
  input  vlsu_frag_pkg::frag_mode_e             req_mode_i,
  input  logic [IdWidth-1:0]                    req_id_i,
  input  logic                                  req_is_load_i,
  input  logic                                  req_vm_i,
  input  logic                                  core_st_pending_i,
  // Transaction output
  output logic                                  txn_valid_o,
  input  logic                                  txn_ready_i,
  output logic [AddrWidth-1:0]                  txn_addr_o,
  output logic [vlsu_frag_pkg::PageBits:0]      txn_bytes_o,
  output logic                                  txn_vm_o,
  // Commit records
  output logic                                  cmt_valid_o,
  input  logic                                  cmt_deq_i,
  output logic [IdWidth-1:0]                    cmt_id_o,
  output logic                                  cmt_is_load_o,
  output logic [vlsu_frag_pkg::TxnCntWidth-1:0] cmt_txn_total_o
);

  logic                                  meta_valid, meta_ready, meta_full, vm;
  logic [AddrWidth-1:0]                  seg_addr;
  logic [vlsu_frag_pkg::TxnCntWidth-1:0] txn_idx, txn_num, enq_txn_total;
  logic [vlsu_frag_pkg::PageBits:0]      last_bytes;
  logic                                  enq, enq_is_load;
  logic [IdWidth-1:0]                    enq_id;

  vreq_fragmenter #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth)
  ) u_frag (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_base_addr_i, .req_sew_i, .req_len_i,
    .req_vstart_i, .req_stride_i, .req_mode_i, .req_id_i, .req_is_load_i,
    .req_vm_i, .core_st_pending_i,
    .meta_full_i     (meta_full),
    .meta_ready_i    (meta_ready),
    .meta_valid_o    (meta_valid),
    .seg_addr_o      (seg_addr),
    .txn_idx_o       (txn_idx),
    .txn_num_o       (txn_num),
    .last_bytes_o    (last_bytes),
    .vm_o            (vm),
    .enq_o           (enq),
    .enq_id_o        (enq_id),
    .enq_is_load_o   (enq_is_load),
    .enq_txn_total_o (enq_txn_total)
  );

  txn_issue_reg #(
    .AddrWidth (AddrWidth)
  ) u_issue (
    .clk_i, .rst_ni,
    .meta_valid_i (meta_valid),
    .meta_ready_o (meta_ready),
    .seg_addr_i   (seg_addr),
    .txn_idx_i    (txn_idx),
    .txn_num_i    (txn_num),
    .last_bytes_i (last_bytes),
    .vm_i         (vm),
    .txn_valid_o, .txn_ready_i, .txn_addr_o, .txn_bytes_o, .txn_vm_o
  );

  cmt_meta_fifo #(
    .IdWidth   (IdWidth),
    .MetaDepth (MetaDepth)
  ) u_cmt (
    .clk_i, .rst_ni,
    .enq_i       (enq),
    .id_i        (enq_id),
    .is_load_i   (enq_is_load),
    .txn_total_i (enq_txn_total),
    .deq_i       (cmt_deq_i),
    .full_o      (meta_full),
    .cmt_valid_o, .cmt_id_o, .cmt_is_load_o, .cmt_txn_total_o
  );

endmodule

/* verif/tb_vlsu_frag.sv */
// --------------------------------------------------------------------------
// Random-request testbench for the vector request splitter. A reference model
// built from the page-split rules predicts every transaction and commit record,
// and assertions compare them with what the DUT emits.
// --------------------------------------------------------------------------
module tb_vlsu_frag;

  localparam int AddrWidth    = 32;
  localparam int IdWidth      = 4;
  localparam int MetaDepth    = 4;
  localparam int Period       = 100;
  localparam int ResetCycles  = 16;
  localparam int NumReqs      = 300;
  localparam int CyclesPerReq = 200;
  localparam int PageSize     = 1 << vlsu_frag_pkg::PageBits;

  logic                                  clk_i, rst_ni;
  logic                                  req_valid_i, req_ready_o;
  logic [AddrWidth-1:0]                  req_base_addr_i, req_stride_i;
  logic [vlsu_frag_pkg::SewWidth-1:0]    req_sew_i;
  logic [vlsu_frag_pkg::LenWidth-1:0]    req_len_i, req_vstart_i;
  vlsu_frag_pkg::frag_mode_e             req_mode_i;
  logic [IdWidth-1:0]                    req_id_i, cmt_id_o;
  logic                                  req_is_load_i, req_vm_i, core_st_pending_i;
  logic                                  txn_valid_o, txn_ready_i, txn_vm_o;
  logic [AddrWidth-1:0]                  txn_addr_o;
  logic [vlsu_frag_pkg::PageBits:0]      txn_bytes_o;
  logic                                  cmt_valid_o, cmt_deq_i, cmt_is_load_o;
  logic [vlsu_frag_pkg::TxnCntWidth-1:0] cmt_txn_total_o;

  // Model state, one entry per transaction or per request
  logic [AddrWidth-1:0] exp_addr_q[$];
  int                   exp_bytes_q[$];
  logic                 exp_vm_q[$];
  int                   req_txn_q[$], req_bytes_q[$], acc_cyc_q[$];
  logic [IdWidth-1:0]   rec_id_q[$];
  logic                 rec_load_q[$];
  int                   rec_total_q[$];
  int seed;
  int acc_cnt = 0;
  int rec_seen = 0;
  int cyc = 0;
  int last_low = 0;
  int txn_in_req = 0;
  int byte_acc = 0;

  vlsu_frag_top #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth),
    .MetaDepth (MetaDepth)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first failed check");
  endtask

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  // Cut one segment at each page boundary
  task automatic split_segment(input logic [AddrWidth-1:0] addr, input int len,
                               input logic vm, inout int pieces);
    int room, piece;
    while (len > 0) begin
      room  = PageSize - int'(addr[vlsu_frag_pkg::PageBits-1:0]);
      piece = (len < room) ? len : room;
      exp_addr_q.push_back(addr);
      exp_bytes_q.push_back(piece);
      exp_vm_q.push_back(vm);
      addr   = addr + AddrWidth'(piece);
      len    = len - piece;
      pieces = pieces + 1;
    end
  endtask

  task automatic predict_request();
    int eff, esz, pieces, total, i;
    logic [AddrWidth-1:0] addr;
    eff    = int'(req_len_i) - int'(req_vstart_i);
    esz    = 1 << req_sew_i;
    pieces = 0;
    if (req_mode_i == vlsu_frag_pkg::MODE_INCR) begin
      // One contiguous span, record counts its pages
      addr = req_base_addr_i + AddrWidth'(req_vstart_i) * AddrWidth'(esz);
      split_segment(addr, eff * esz, req_vm_i, pieces);
      total = pieces;
    end else begin
      // One element per segment, record counts elements only
      for (i = 0; i < eff; i++) begin
        addr = req_base_addr_i + (AddrWidth'(req_vstart_i) + AddrWidth'(i)) * req_stride_i;
        split_segment(addr, esz, req_vm_i, pieces);
      end
      total = eff;
    end
    req_txn_q.push_back(pieces);
    req_bytes_q.push_back(eff * esz);
    rec_id_q.push_back(req_id_i);
    rec_load_q.push_back(req_is_load_i);
    rec_total_q.push_back(total);
  endtask

  task automatic check_txn();
    logic [AddrWidth-1:0] e_addr;
    int e_bytes;
    logic e_vm;
    assert (exp_addr_q.size() != 0) else fail_check("transaction with none expected");
    e_addr  = exp_addr_q.pop_front();
    e_bytes = exp_bytes_q.pop_front();
    e_vm    = exp_vm_q.pop_front();
    assert (txn_addr_o == e_addr && int'(txn_bytes_o) == e_bytes && txn_vm_o == e_vm)
      else fail_check($sformatf("transaction %h/%0d/%0b, expected %h/%0d/%0b",
                                txn_addr_o, txn_bytes_o, txn_vm_o, e_addr, e_bytes, e_vm));
    // Bytes the DUT actually moved for this request
    byte_acc = byte_acc + int'(txn_bytes_o);
    // Fragmenting needs at least one cycle without a pending core store
    if (txn_in_req == 0) begin
      assert (last_low > acc_cyc_q[0])
        else fail_check("first transaction while core store stayed pending");
      void'(acc_cyc_q.pop_front());
    end
    txn_in_req = txn_in_req + 1;
    if (txn_in_req == req_txn_q[0]) begin
      assert (byte_acc == req_bytes_q[0])
        else fail_check($sformatf("request moved %0d bytes, expected %0d",
                                  byte_acc, req_bytes_q[0]));
      void'(req_txn_q.pop_front());
      void'(req_bytes_q.pop_front());
      txn_in_req = 0;
      byte_acc   = 0;
    end
  endtask

  task automatic check_record();
    assert (rec_id_q.size() != 0) else fail_check("commit record with no request");
    assert (cmt_id_o == rec_id_q[0] && cmt_is_load_o == rec_load_q[0]
            && int'(cmt_txn_total_o) == rec_total_q[0])
      else fail_check($sformatf("record id %0d load %0b total %0d, expected %0d %0b %0d",
                                cmt_id_o, cmt_is_load_o, cmt_txn_total_o,
                                rec_id_q[0], rec_load_q[0], rec_total_q[0]));
    void'(rec_id_q.pop_front());
    void'(rec_load_q.pop_front());
    void'(rec_total_q.pop_front());
    rec_seen = rec_seen + 1;
  endtask

  // Handshakes sampled at the rising edge, inputs settled since the falling one
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cyc <= cyc + 1;
      if (!core_st_pending_i) last_low <= cyc;
      if (txn_valid_o && txn_ready_i) check_txn();
      if (cmt_valid_o && cmt_deq_i) check_record();
      if (req_valid_i && req_ready_o) begin
        predict_request();
        acc_cyc_q.push_back(cyc);
        acc_cnt <= acc_cnt + 1;
      end
    end
  end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_valid_o && !txn_ready_i |=> txn_valid_o && $stable(txn_addr_o) && $stable(txn_bytes_o))
    else fail_check("transaction changed under back-pressure");

  a_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_valid_o |-> txn_bytes_o != '0
      && int'(txn_addr_o[vlsu_frag_pkg::PageBits-1:0]) + int'(txn_bytes_o) <= PageSize)
    else fail_check("transaction empty or crossing a page");

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic drive_levels();
    txn_ready_i = ($random(seed) & 3) != 0;
    cmt_deq_i   = ($random(seed) & 3) == 0;
    // Rare flips give long pending stretches
    if (($random(seed) & 7) == 0) core_st_pending_i = !core_st_pending_i;
  endtask

  task automatic drive_request();
    vlsu_frag_pkg::frag_mode_e mode;
    int len, vstart;
    logic [AddrWidth-1:0] base;
    mode = (($random(seed) & 1) != 0) ? vlsu_frag_pkg::MODE_STRD : vlsu_frag_pkg::MODE_INCR;
    len  = (mode == vlsu_frag_pkg::MODE_STRD) ? ($unsigned($random(seed)) % 32) + 1
                                              : ($unsigned($random(seed)) % 256) + 1;
    vstart = $unsigned($random(seed)) % len;
    // Bases mostly in the last 64 bytes of a page
    base = {$random(seed)} & 32'h0fff_f000;
    if (($random(seed) & 3) != 0) base = base | (32'hfff - ({$random(seed)} & 32'h3f));
    else base = base | ({$random(seed)} & 32'hfff);
    req_mode_i      = mode;
    req_base_addr_i = base;
    req_len_i       = vlsu_frag_pkg::LenWidth'(len);
    req_vstart_i    = vlsu_frag_pkg::LenWidth'(vstart);
    req_sew_i       = vlsu_frag_pkg::SewWidth'($random(seed));
    req_stride_i    = ((32'({$random(seed)}) & 32'h3) << 12) + ({$random(seed)} & 32'h1f);
    req_id_i        = IdWidth'($random(seed));
    req_is_load_i   = 1'($random(seed));
    req_vm_i        = 1'($random(seed));
    req_valid_i     = 1'b1;
  endtask

  initial begin
    int issued;
    seed              = 32'h27da_3e50;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_base_addr_i   = '0;
    req_sew_i         = '0;
    req_len_i         = '0;
    req_vstart_i      = '0;
    req_stride_i      = '0;
    req_mode_i        = vlsu_frag_pkg::MODE_INCR;
    req_id_i          = '0;
    req_is_load_i     = 1'b0;
    req_vm_i          = 1'b0;
    core_st_pending_i = 1'b0;
    txn_ready_i       = 1'b0;
    cmt_deq_i         = 1'b0;
    issued            = 0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    assert (!txn_valid_o && !cmt_valid_o && req_ready_o)
      else fail_check("outputs not idle after reset");
    while (acc_cnt < NumReqs) begin
      @(negedge clk_i);
      drive_levels();
      if (req_valid_i && acc_cnt == issued) req_valid_i = 1'b0;
      if (!req_valid_i && issued < NumReqs && ($random(seed) & 1) != 0) begin
        drive_request();
        issued = issued + 1;
      end
    end
    // Drain the last transactions and records
    while (exp_addr_q.size() != 0 || rec_id_q.size() != 0) begin
      @(negedge clk_i);
      drive_levels();
    end
    if (rec_seen == NumReqs && req_txn_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_check($sformatf("%0d records seen for %0d requests", rec_seen, NumReqs));
    end
  end

  // Watchdog sized for the whole request stream
  initial begin
    #((ResetCycles + NumReqs * CyclesPerReq) * Period);
    $display("Watchdog expired at time %0t, the run hung before all requests finished",
             $time);
    $display("TEST FAIL");
    $fatal(1, "simulation hung");
  end

endmodule

/* vlog.f */
verilog/vlsu_frag_pkg.sv
verilog/seg_txn_plan.sv
verilog/vreq_fragmenter.sv
verilog/txn_issue_reg.sv
verilog/cmt_meta_fifo.sv
verilog/vlsu_frag_top.sv
verif/tb_vlsu_frag.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_vlsu_frag -o tb_vlsu_frag
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_vlsu_frag
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with failure status $status"
  exit "$status"
fi

echo "Simulation ended cleanly"
exit 0
